//--- hw/lz77_params.svh
// -------------------
// lz77 compressor sizes
// window, match lengths and link FIFO depths
// -------------------
`ifndef LZ77_PARAMS_SVH
`define LZ77_PARAMS_SVH

// history and lookahead
`define LZ_WIN_SIZE 32
`define LZ_MAX_LEN 16
`define LZ_MIN_LEN_DEF 3

// credit link depths
`define LZ_IN_DEPTH 4
`define LZ_OUT_DEPTH 4

// widths hold the full range, 0 up to the maximum
`define LZ_LEN_WD ($clog2(`LZ_MAX_LEN + 1))
`define LZ_DST_WD ($clog2(`LZ_WIN_SIZE + 1))

`endif

//--- hw/lz77_pkg.sv
// -------------------
// lz77 shared types
// data byte, length, distance, input beat and output token
// -------------------
`default_nettype none

`include "lz77_params.svh"

package lz77_pkg;

  typedef logic [7:0] byte_t;

  typedef logic [`LZ_LEN_WD-1:0] len_t;

  typedef logic [`LZ_DST_WD-1:0] dst_t;

  // one byte from the input link
  typedef struct packed {
    logic  last;
    byte_t data;
  } in_beat_t;

  // literal when lit is set, else a length/distance pair
  typedef struct packed {
    logic  lit;
    byte_t lit_byte;
    len_t  len;
    dst_t  dst;
    logic  last;
  } token_t;

endpackage

`default_nettype wire

//--- hw/lz77_cfg_regs.sv
// -------------------
// lz77 configuration registers
// min length and max distance, captured at block start
// and clamped to the legal range
// -------------------
`timescale 1ns/1ns
`default_nettype none

`include "lz77_params.svh"

module lz77_cfg_regs (
  input  wire                 clk,
  input  wire                 rstn,
  input  wire                 load_i,
  input  wire lz77_pkg::len_t min_len_i,
  input  wire lz77_pkg::dst_t max_dist_i,
  output lz77_pkg::len_t      min_len_o,
  output lz77_pkg::dst_t      max_dist_o
);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      min_len_o  <= lz77_pkg::len_t'(`LZ_MIN_LEN_DEF);
      max_dist_o <= lz77_pkg::dst_t'(`LZ_WIN_SIZE);
    end else if (load_i) begin
      // a match shorter than 2 never saves anything
      if (min_len_i < lz77_pkg::len_t'(2)) begin
        min_len_o <= lz77_pkg::len_t'(2);
      end else if (min_len_i > lz77_pkg::len_t'(`LZ_MAX_LEN)) begin
        min_len_o <= lz77_pkg::len_t'(`LZ_MAX_LEN);
      end else begin
        min_len_o <= min_len_i;
      end
      // distance 0 has no meaning, beyond the window there is no history
      if (max_dist_i == '0) begin
        max_dist_o <= lz77_pkg::dst_t'(1);
      end else if (max_dist_i > lz77_pkg::dst_t'(`LZ_WIN_SIZE)) begin
        max_dist_o <= lz77_pkg::dst_t'(`LZ_WIN_SIZE);
      end else begin
        max_dist_o <= max_dist_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/lz77_credit_fifo.sv
// -------------------
// credit based FIFO
// pops the head while it holds a downstream credit,
// every pop hands one credit back upstream
// -------------------
`timescale 1ns/1ns
`default_nettype none

module lz77_credit_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [7:0]
) (
  input  wire           clk,
  input  wire           rstn,
  input  wire           push_i,
  input  wire payload_t push_data_i,
  input  wire           credit_i,
  output logic          pop_o,
  output payload_t      pop_data_o,
  output logic          credit_o
);

  localparam int PTR_WD = $clog2(DEPTH);
  localparam int CNT_WD = $clog2(DEPTH + 1);
  localparam int CRD_WD = 8;

  payload_t          mem [DEPTH];
  logic [PTR_WD-1:0] wr_ptr_r;
  logic [PTR_WD-1:0] rd_ptr_r;
  logic [CNT_WD-1:0] cnt_r;
  logic [CRD_WD-1:0] crd_r;

  assign pop_o      = (cnt_r != '0) && (crd_r != '0);
  assign pop_data_o = mem[rd_ptr_r];
  assign credit_o   = pop_o;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_r] <= push_data_i;
    end
  end

  // -------------------
  // pointers and counts
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      cnt_r    <= '0;
      crd_r    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= (wr_ptr_r == PTR_WD'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_r <= (rd_ptr_r == PTR_WD'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      cnt_r <= cnt_r + CNT_WD'(push_i) - CNT_WD'(pop_o);
      crd_r <= crd_r + CRD_WD'(credit_i) - CRD_WD'(pop_o);
    end
  end

  // sender only pushes on credits it was handed back
  assert property (@(posedge clk) disable iff (!rstn)
    push_i |-> (cnt_r != CNT_WD'(DEPTH)) || pop_o);

  // receiver grants no more credits than it has slots
  assert property (@(posedge clk) disable iff (!rstn)
    credit_i && !pop_o |-> crd_r != '1);

endmodule

`default_nettype wire

//--- hw/lz77_window_buf.sv
// -------------------
// lz77 window and lookahead
// shift registers for history and lookahead, one byte per
// cycle on advance, refilled from the input FIFO by credits
// -------------------
`timescale 1ns/1ns
`default_nettype none

`include "lz77_params.svh"

module lz77_window_buf (
  input  wire                                     clk,
  input  wire                                     rstn,
  input  wire                                     clear_i,
  input  wire                                     fill_req_i,
  input  wire                                     in_pop_i,
  input  wire lz77_pkg::in_beat_t                 in_beat_i,
  output logic                                    in_credit_o,
  input  wire lz77_pkg::len_t                     advance_i,
  output lz77_pkg::byte_t [`LZ_WIN_SIZE-1:0]      win_o,
  output lz77_pkg::byte_t [`LZ_MAX_LEN-1:0]       look_o,
  output lz77_pkg::dst_t                          win_len_o,
  output lz77_pkg::len_t                          look_len_o,
  output logic                                    look_has_last_o,
  output logic                                    fill_done_o
);

  lz77_pkg::len_t adv_cnt_r;
  logic           pend_r;
  logic           shift;
  logic           room;

  assign shift = adv_cnt_r != '0;

  // one byte in flight, the next request can go out as it lands
  always_comb begin
    if (pend_r) begin
      room = in_pop_i && !in_beat_i.last &&
             (look_len_o < lz77_pkg::len_t'(`LZ_MAX_LEN - 1));
    end else begin
      room = look_len_o < lz77_pkg::len_t'(`LZ_MAX_LEN);
    end
  end

  assign in_credit_o = fill_req_i && !shift && !look_has_last_o && room;

  // full lookahead, or everything up to the end of the block
  assign fill_done_o = fill_req_i && !shift && !pend_r && (look_len_o != '0) &&
                       (look_has_last_o || look_len_o == lz77_pkg::len_t'(`LZ_MAX_LEN));

  // -------------------
  // lengths and requests
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      adv_cnt_r       <= '0;
      pend_r          <= 1'b0;
      win_len_o       <= '0;
      look_len_o      <= '0;
      look_has_last_o <= 1'b0;
    end else if (clear_i) begin
      adv_cnt_r       <= '0;
      pend_r          <= 1'b0;
      win_len_o       <= '0;
      look_len_o      <= '0;
      look_has_last_o <= 1'b0;
    end else begin
      if (advance_i != '0) begin
        adv_cnt_r <= advance_i;
      end else if (shift) begin
        adv_cnt_r <= adv_cnt_r - 1'b1;
      end
      if (in_credit_o) begin
        pend_r <= 1'b1;
      end else if (in_pop_i) begin
        pend_r <= 1'b0;
      end
      if (shift) begin
        look_len_o <= look_len_o - 1'b1;
        if (win_len_o != lz77_pkg::dst_t'(`LZ_WIN_SIZE)) begin
          win_len_o <= win_len_o + 1'b1;
        end
      end else if (in_pop_i) begin
        look_len_o <= look_len_o + 1'b1;
        if (in_beat_i.last) begin
          look_has_last_o <= 1'b1;
        end
      end
    end
  end

  // -------------------
  // byte storage
  // win_o[0] is distance 1, look_o[0] is the next byte to code
  always_ff @(posedge clk) begin
    if (shift) begin
      win_o  <= {win_o[`LZ_WIN_SIZE-2:0], look_o[0]};
      look_o <= {lz77_pkg::byte_t'(0), look_o[`LZ_MAX_LEN-1:1]};
    end else if (in_pop_i) begin
      look_o[look_len_o] <= in_beat_i.data;
    end
  end

  // the FIFO only pops against a credit we sent
  assert property (@(posedge clk) disable iff (!rstn) in_pop_i |-> pend_r);

endmodule

`default_nettype wire

//--- hw/lz77_match_search.sv
// -------------------
// lz77 match search
// narrows one flag per distance a byte per cycle, keeps the
// nearest survivor, then pushes a literal or a match token
// -------------------
`timescale 1ns/1ns
`default_nettype none

`include "lz77_params.svh"

module lz77_match_search (
  input  wire                                     clk,
  input  wire                                     rstn,
  input  wire                                     start_i,
  input  wire lz77_pkg::byte_t [`LZ_WIN_SIZE-1:0] win_i,
  input  wire lz77_pkg::byte_t [`LZ_MAX_LEN-1:0]  look_i,
  input  wire lz77_pkg::dst_t                     win_len_i,
  input  wire lz77_pkg::len_t                     look_len_i,
  input  wire                                     look_has_last_i,
  input  wire lz77_pkg::len_t                     min_len_i,
  input  wire lz77_pkg::dst_t                     max_dist_i,
  output logic                                    push_o,
  output lz77_pkg::token_t                        tok_o,
  output lz77_pkg::len_t                          advance_o,
  output logic                                    busy_o
);

  typedef enum logic [1:0] {
    SR_IDLE,
    SR_STEP,
    SR_PUSH
  } state_t;

  state_t                  state_r;
  logic [`LZ_WIN_SIZE-1:0] flags_r;
  logic [`LZ_WIN_SIZE-1:0] flags_init;
  logic [`LZ_WIN_SIZE-1:0] flags_nxt;
  lz77_pkg::len_t          step_r;
  lz77_pkg::len_t          best_len_r;
  lz77_pkg::dst_t          best_dst_r;
  lz77_pkg::len_t          adv;
  logic                    is_lit;
  logic                    stop;

  // lowest set flag is the nearest distance
  function automatic lz77_pkg::dst_t nearest_dst(input logic [`LZ_WIN_SIZE-1:0] flags);
    lz77_pkg::dst_t dst;
    dst = '0;
    for (int i = `LZ_WIN_SIZE - 1; i >= 0; i--) begin
      if (flags[i]) begin
        dst = lz77_pkg::dst_t'(i + 1);
      end
    end
    return dst;
  endfunction

  // -------------------
  // flag narrowing
  // flag d-1 stands for distance d, step k compares look[k] with win[d-1-k]
  always_comb begin
    for (int d = 1; d <= `LZ_WIN_SIZE; d++) begin
      flags_init[d-1] = (d <= int'(win_len_i)) && (d <= int'(max_dist_i));
      flags_nxt[d-1]  = 1'b0;
      // k >= d would reach into the lookahead itself
      if (int'(step_r) < d) begin
        flags_nxt[d-1] = flags_r[d-1] && (look_i[step_r] == win_i[d - 1 - int'(step_r)]);
      end
    end
  end

  assign stop = (flags_nxt == '0) || (step_r + 1'b1 >= look_len_i);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r <= SR_IDLE;
    end else begin
      case (state_r)
        SR_IDLE: if (start_i) state_r <= SR_STEP;
        SR_STEP: if (stop) state_r <= SR_PUSH;
        default: state_r <= SR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_r == SR_IDLE && start_i) begin
      flags_r    <= flags_init;
      step_r     <= '0;
      best_len_r <= '0;
      best_dst_r <= '0;
    end else if (state_r == SR_STEP) begin
      flags_r <= flags_nxt;
      step_r  <= step_r + 1'b1;
      if (flags_nxt != '0) begin
        best_len_r <= step_r + 1'b1;
        best_dst_r <= nearest_dst(flags_nxt);
      end
    end
  end

  // -------------------
  // token
  assign is_lit    = best_len_r < min_len_i;
  assign adv       = is_lit ? lz77_pkg::len_t'(1) : best_len_r;
  assign push_o    = state_r == SR_PUSH;
  assign busy_o    = state_r != SR_IDLE;
  assign advance_o = push_o ? adv : '0;

  always_comb begin
    tok_o.lit      = is_lit;
    tok_o.lit_byte = look_i[0];
    tok_o.len      = adv;
    tok_o.dst      = is_lit ? '0 : best_dst_r;
    tok_o.last     = look_has_last_i && (adv == look_len_i);
  end

  assert property (@(posedge clk) disable iff (!rstn)
    push_o && !tok_o.lit |-> tok_o.dst != '0);

endmodule

`default_nettype wire

//--- hw/lz77_ctrl.sv
// -------------------
// lz77 block control
// sequences fill and search per token and keeps the
// output credit count
// -------------------
`timescale 1ns/1ns
`default_nettype none

`include "lz77_params.svh"

module lz77_ctrl (
  input  wire  clk,
  input  wire  rstn,
  input  wire  start_i,
  input  wire  out_credit_i,
  input  wire  push_i,
  input  wire  tok_last_i,
  input  wire  fill_done_i,
  input  wire  search_busy_i,
  output logic idle_o,
  output logic clear_o,
  output logic fill_req_o,
  output logic search_start_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_SEARCH,
    ST_WAIT_CREDIT
  } state_t;

  localparam int CRD_WD = $clog2(`LZ_OUT_DEPTH + 1);

  state_t            state_r;
  state_t            state_nxt;
  logic [CRD_WD-1:0] crd_r;
  logic              has_crd;
  logic              blk_end;

  assign has_crd    = crd_r != '0;
  assign idle_o     = state_r == ST_IDLE;
  assign clear_o    = idle_o && start_i;
  assign fill_req_o = state_r == ST_FILL;

  // last token leaving the output FIFO ends the block
  assign blk_end = !idle_o && out_credit_i && tok_last_i;

  // -------------------
  // fsm
  always_comb begin
    state_nxt      = state_r;
    search_start_o = 1'b0;
    case (state_r)
      ST_IDLE: begin
        if (start_i) state_nxt = ST_FILL;
      end
      ST_FILL: begin
        if (fill_done_i && !search_busy_i) begin
          search_start_o = has_crd;
          state_nxt      = has_crd ? ST_SEARCH : ST_WAIT_CREDIT;
        end
      end
      ST_WAIT_CREDIT: begin
        search_start_o = has_crd;
        if (has_crd) state_nxt = ST_SEARCH;
      end
      ST_SEARCH: begin
        if (push_i) state_nxt = ST_FILL;
      end
      default: state_nxt = ST_IDLE;
    endcase
    if (blk_end) state_nxt = ST_IDLE;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r <= ST_IDLE;
      crd_r   <= CRD_WD'(`LZ_OUT_DEPTH);
      done_o  <= 1'b0;
    end else begin
      state_r <= state_nxt;
      crd_r   <= crd_r + CRD_WD'(out_credit_i) - CRD_WD'(push_i);
      done_o  <= blk_end;
    end
  end

  // search only pushes inside SEARCH, on a credit reserved at its start
  assert property (@(posedge clk) disable iff (!rstn)
    push_i |-> state_r == ST_SEARCH && has_crd);

endmodule

`default_nettype wire

//--- hw/lz77_top.sv
// -------------------
// lz77 compressor top
// credit links on input bytes and output tokens
// -------------------
`timescale 1ns/1ns
`default_nettype none

`include "lz77_params.svh"

module lz77_top (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire                   start_i,
  input  wire lz77_pkg::len_t   cfg_min_len_i,
  input  wire lz77_pkg::dst_t   cfg_max_dist_i,
  input  wire                   in_valid_i,
  input  wire lz77_pkg::byte_t  in_data_i,
  input  wire                   in_last_i,
  output wire                   in_credit_o,
  input  wire                   tok_credit_i,
  output wire                   tok_valid_o,
  output wire lz77_pkg::token_t tok_o,
  output wire                   done_o
);

  lz77_pkg::len_t                    cfg_min_len;
  lz77_pkg::dst_t                    cfg_max_dist;
  logic                              cfg_load;
  logic                              ctrl_idle;
  logic                              win_clear;
  logic                              fill_req;
  logic                              fill_done;
  logic                              search_start;
  logic                              search_busy;
  logic                              in_pop;
  lz77_pkg::in_beat_t                in_beat;
  logic                              win_credit;
  lz77_pkg::byte_t [`LZ_WIN_SIZE-1:0] win;
  lz77_pkg::byte_t [`LZ_MAX_LEN-1:0]  look;
  lz77_pkg::dst_t                    win_len;
  lz77_pkg::len_t                    look_len;
  logic                              look_has_last;
  logic                              tok_push;
  lz77_pkg::token_t                  tok_push_data;
  lz77_pkg::len_t                    advance;
  logic                              out_credit;

  assign cfg_load = start_i & ctrl_idle;

  lz77_cfg_regs u_cfg (
    .clk(clk), .rstn(rstn), .load_i(cfg_load),
    .min_len_i(cfg_min_len_i), .max_dist_i(cfg_max_dist_i),
    .min_len_o(cfg_min_len), .max_dist_o(cfg_max_dist)
  );

  lz77_credit_fifo #(.DEPTH(`LZ_IN_DEPTH), .payload_t(lz77_pkg::in_beat_t)) u_in_fifo (
    .clk(clk), .rstn(rstn),
    .push_i(in_valid_i), .push_data_i({in_last_i, in_data_i}),
    .credit_i(win_credit), .pop_o(in_pop), .pop_data_o(in_beat),
    .credit_o(in_credit_o)
  );

  lz77_window_buf u_window (
    .clk(clk), .rstn(rstn), .clear_i(win_clear), .fill_req_i(fill_req),
    .in_pop_i(in_pop), .in_beat_i(in_beat), .in_credit_o(win_credit),
    .advance_i(advance), .win_o(win), .look_o(look),
    .win_len_o(win_len), .look_len_o(look_len),
    .look_has_last_o(look_has_last), .fill_done_o(fill_done)
  );

  lz77_match_search u_search (
    .clk(clk), .rstn(rstn), .start_i(search_start),
    .win_i(win), .look_i(look), .win_len_i(win_len), .look_len_i(look_len),
    .look_has_last_i(look_has_last),
    .min_len_i(cfg_min_len), .max_dist_i(cfg_max_dist),
    .push_o(tok_push), .tok_o(tok_push_data), .advance_o(advance),
    .busy_o(search_busy)
  );

  lz77_credit_fifo #(.DEPTH(`LZ_OUT_DEPTH), .payload_t(lz77_pkg::token_t)) u_out_fifo (
    .clk(clk), .rstn(rstn),
    .push_i(tok_push), .push_data_i(tok_push_data),
    .credit_i(tok_credit_i), .pop_o(tok_valid_o), .pop_data_o(tok_o),
    .credit_o(out_credit)
  );

  lz77_ctrl u_ctrl (
    .clk(clk), .rstn(rstn), .start_i(start_i),
    .out_credit_i(out_credit), .push_i(tok_push), .tok_last_i(tok_o.last),
    .fill_done_i(fill_done), .search_busy_i(search_busy),
    .idle_o(ctrl_idle), .clear_o(win_clear), .fill_req_o(fill_req),
    .search_start_o(search_start), .done_o(done_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_lz77_ref.svh
// -------------------
// lz77 reference model
// byte pattern generator and a greedy compressor that
// predicts the token stream of one block
// -------------------
`ifndef TB_LZ77_REF_SVH
`define TB_LZ77_REF_SVH

localparam int BLK_MAX    = 64;
localparam int PAT_UNIQUE = 0;
localparam int PAT_REPEAT = 1;
localparam int PAT_CONST  = 2;
localparam int PAT_MIXED  = 3;

lz77_pkg::byte_t  blk_data [BLK_MAX];
lz77_pkg::token_t exp_q [$];

// fills blk_data with len bytes of the given kind
function automatic void gen_block(input int kind, input int len);
  lz77_pkg::byte_t base;
  lz77_pkg::byte_t step;
  int              period;
  base   = lz77_pkg::byte_t'($random(seed));
  // odd step walks all 256 values before repeating
  step   = lz77_pkg::byte_t'($random(seed)) | 8'h01;
  period = 2 + ($random(seed) & 3);
  for (int i = 0; i < len; i++) begin
    case (kind)
      PAT_UNIQUE: blk_data[i] = base + lz77_pkg::byte_t'(i) * step;
      PAT_REPEAT: begin
        if (i < period) begin
          blk_data[i] = lz77_pkg::byte_t'($random(seed));
        end else begin
          blk_data[i] = blk_data[i - period];
        end
      end
      PAT_CONST: blk_data[i] = base;
      // small alphabet gives many short matches
      default: blk_data[i] = lz77_pkg::byte_t'($random(seed) & 3);
    endcase
  end
endfunction

// greedy longest match, nearest distance on ties
function automatic void ref_compress(input int len, input int min_len_in, input int max_dist_in);
  int               min_len;
  int               max_dist;
  int               p;
  int               best_len;
  int               best_dst;
  int               l;
  lz77_pkg::token_t tok;
  min_len  = (min_len_in < 2) ? 2 : (min_len_in > `LZ_MAX_LEN) ? `LZ_MAX_LEN : min_len_in;
  max_dist = (max_dist_in < 1) ? 1 :
             (max_dist_in > `LZ_WIN_SIZE) ? `LZ_WIN_SIZE : max_dist_in;
  exp_q.delete();
  p = 0;
  while (p < len) begin
    best_len = 0;
    best_dst = 0;
    for (int d = 1; d <= p && d <= max_dist; d++) begin
      l = 0;
      // the copy source may not run into position p
      while (l < `LZ_MAX_LEN && l < len - p && l < d &&
             blk_data[p - d + l] == blk_data[p + l]) begin
        l++;
      end
      if (l > best_len) begin
        best_len = l;
        best_dst = d;
      end
    end
    tok.lit_byte = blk_data[p];
    if (best_len >= min_len) begin
      tok.lit = 1'b0;
      tok.len = lz77_pkg::len_t'(best_len);
      tok.dst = lz77_pkg::dst_t'(best_dst);
    end else begin
      tok.lit = 1'b1;
      tok.len = lz77_pkg::len_t'(1);
      tok.dst = '0;
    end
    tok.last = (p + int'(tok.len)) == len;
    exp_q.push_back(tok);
    p = p + int'(tok.len);
  end
endfunction

`endif

//--- tb/tb_lz77.sv
// -------------------
// lz77 compressor testbench
// sends table driven blocks over the input credit link and
// checks each token against the reference model
// -------------------
`timescale 1ns/1ns
`default_nettype none

`include "lz77_params.svh"

module tb_lz77;

  localparam int TIMEOUT_CYC = 20000;
  localparam int RX_SLOTS    = 4;
  localparam int NUM_ROWS    = 11;

  // one block per row
  typedef struct packed {
    int   kind;
    int   len;
    int   min_len;
    int   max_dist;
    int   gap;
    logic all_lit;
  } row_t;

  logic             clk;
  logic             rstn;
  logic             start;
  lz77_pkg::len_t   cfg_min_len;
  lz77_pkg::dst_t   cfg_max_dist;
  logic             in_valid;
  lz77_pkg::byte_t  in_data;
  logic             in_last;
  logic             in_credit;
  logic             tok_credit;
  logic             tok_valid;
  lz77_pkg::token_t tok;
  logic             done;

  integer seed;
  row_t   rows [NUM_ROWS];
  int     in_crd;
  int     granted;
  int     received;

  `include "tb_lz77_ref.svh"

  lz77_top UUT (
    .clk(clk), .rstn(rstn), .start_i(start),
    .cfg_min_len_i(cfg_min_len), .cfg_max_dist_i(cfg_max_dist),
    .in_valid_i(in_valid), .in_data_i(in_data), .in_last_i(in_last),
    .in_credit_o(in_credit), .tok_credit_i(tok_credit),
    .tok_valid_o(tok_valid), .tok_o(tok), .done_o(done)
  );

  always #50 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t ns: %s, got %0h, expected %0h",
                         $time, what, got, exp));
    end
  endtask

  // kind, length, min_len, max_dist, credit gap, literals only
  task automatic fill_table();
    rows[0]  = '{PAT_UNIQUE, 40, 3, 32, 0, 1'b1};
    rows[1]  = '{PAT_REPEAT, 60, 3, 32, 0, 1'b0};
    rows[2]  = '{PAT_CONST, 48, 3, 32, 0, 1'b0};
    rows[3]  = '{PAT_MIXED, 64, 3, 32, 0, 1'b0};
    rows[4]  = '{PAT_MIXED, 64, 2, 8, 0, 1'b0};
    rows[5]  = '{PAT_MIXED, 64, 5, 32, 0, 1'b0};
    rows[6]  = '{PAT_REPEAT, 60, 4, 4, 0, 1'b0};
    rows[7]  = '{PAT_MIXED, 50, 3, 32, 25, 1'b0};
    rows[8]  = '{PAT_REPEAT, 40, 0, 0, 7, 1'b0};
    rows[9]  = '{PAT_UNIQUE, 1, 3, 32, 3, 1'b1};
    rows[10] = '{PAT_MIXED, 64, 20, 40, 1, 1'b0};
  endtask

  task automatic run_block(input int r);
    row_t row;
    int   sent;
    int   idx;
    int   cyc;
    int   gap_cnt;
    logic last_seen;
    logic finished;
    row = rows[r];
    gen_block(row.kind, row.len);
    ref_compress(row.len, row.min_len, row.max_dist);
    sent      = 0;
    idx       = 0;
    cyc       = 0;
    gap_cnt   = 0;
    last_seen = 1'b0;
    finished  = 1'b0;
    start        = 1'b1;
    cfg_min_len  = lz77_pkg::len_t'(row.min_len);
    cfg_max_dist = lz77_pkg::dst_t'(row.max_dist);
    while (!finished) begin
      // sender spends one credit per byte
      if (sent < row.len && in_crd > 0) begin
        in_valid = 1'b1;
        in_data  = blk_data[sent];
        in_last  = (sent == row.len - 1);
        sent++;
        in_crd--;
      end else begin
        in_valid = 1'b0;
        in_last  = 1'b0;
      end
      // receiver grants only free slots, spaced by the gap
      if (granted - received < RX_SLOTS && gap_cnt >= row.gap) begin
        tok_credit = 1'b1;
        granted++;
        gap_cnt = 0;
      end else begin
        tok_credit = 1'b0;
        gap_cnt++;
      end
      @(negedge clk);
      start = 1'b0;
      cyc++;
      if (in_credit) begin
        in_crd++;
      end
      check_value(in_crd <= `LZ_IN_DEPTH, 1, "input credits held by the sender");
      check_value(done, last_seen, "done_o one cycle after the last token");
      finished  = done;
      last_seen = 1'b0;
      if (tok_valid) begin
        if (idx >= exp_q.size()) begin
          fail_run($sformatf("block %0d sent more tokens than expected", r));
        end
        check_value(received < granted, 1, "token only against a granted credit");
        received++;
        check_value(tok.lit, exp_q[idx].lit, "token literal flag");
        check_value(tok.lit_byte, exp_q[idx].lit_byte, "token byte");
        check_value(tok.len, exp_q[idx].len, "token length");
        check_value(tok.dst, exp_q[idx].dst, "token distance");
        check_value(tok.last, exp_q[idx].last, "token last flag");
        if (row.all_lit) begin
          check_value(tok.lit, 1, "literal in a block without repeats");
          check_value(tok.lit_byte, blk_data[idx], "literal equals the input byte");
        end
        last_seen = tok.last;
        idx++;
      end
      if (cyc >= TIMEOUT_CYC) begin
        fail_run($sformatf("timeout: block %0d did not end within %0d cycles",
                           r, TIMEOUT_CYC));
      end
    end
    tok_credit = 1'b0;
    in_valid   = 1'b0;
    check_value(idx, exp_q.size(), "token count of the block");
    check_value(in_crd, `LZ_IN_DEPTH, "input credits back at block end");
  endtask

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    start        = 1'b0;
    cfg_min_len  = '0;
    cfg_max_dist = '0;
    in_valid     = 1'b0;
    in_data      = '0;
    in_last      = 1'b0;
    tok_credit   = 1'b0;
    seed         = 32'h1667_9e70;
    in_crd       = `LZ_IN_DEPTH;
    granted      = 0;
    received     = 0;
    fill_table();
    repeat (2) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_value(in_credit, 0, "in_credit_o after reset");
    check_value(tok_valid, 0, "tok_valid_o after reset");
    check_value(done, 0, "done_o after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_block(r);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
+incdir+tb
hw/lz77_pkg.sv
hw/lz77_cfg_regs.sv
hw/lz77_credit_fifo.sv
hw/lz77_window_buf.sv
hw/lz77_match_search.sv
hw/lz77_ctrl.sv
hw/lz77_top.sv
tb/tb_lz77.sv

//--- Bender.yml
package:
  name: lz77

sources:
  - include_dirs:
      - hw
    files:
      - hw/lz77_pkg.sv
      - hw/lz77_cfg_regs.sv
      - hw/lz77_credit_fifo.sv
      - hw/lz77_window_buf.sv
      - hw/lz77_match_search.sv
      - hw/lz77_ctrl.sv
      - hw/lz77_top.sv
  - target: test
    include_dirs:
      - hw
      - tb
    files:
      - tb/tb_lz77.sv
